// File: flist.f
+incdir+verif
design/decode_pkg.sv
design/imm_gen.sv
design/ctrl_decoder.sv
design/reg_file.sv
design/decode_stage.sv
verif/tb_decode_stage.sv

// File: Makefile
SRCS := $(filter %.sv,$(shell cat flist.f)) verif/tb_decode_vectors.svh

.PHONY: run clean

run: obj_dir/Vtb_decode_stage
	./obj_dir/Vtb_decode_stage | tee /dev/stderr | grep -q "Everything OK"

obj_dir/Vtb_decode_stage: flist.f $(SRCS)
	verilator --binary --timing -f flist.f --top-module tb_decode_stage

clean:
	rm -rf obj_dir

// File: verif/tb_decode_vectors.svh
// Decode vector record type and table of instruction words with expected controls
`ifndef TB_DECODE_VECTORS_SVH
`define TB_DECODE_VECTORS_SVH

   typedef struct {
      logic [31:0]       instr;
      logic              fetch_req;
      exc_code_e         fetch_code;
      alu_ops_e          alu;
      ld_ops_e           ld;
      st_ops_e           st;
      br_ops_e           br;
      alu_opr1_sel_e     opr1;
      alu_opr2_sel_e     opr2;
      alu_cmp_opr2_sel_e cmp;
      rd_wrb_sel_e       wrb;
      logic [2:0]        reqs;                     // {rd_wr_req, jump_req, branch_req}
      logic              exc;
      exc_code_e         code;
      logic [31:0]       imm;
   } vector_t;

   vector_t vectors[$];

   task automatic add_legal(input logic [31:0] instr, input alu_ops_e alu, input ld_ops_e ld,
                            input st_ops_e st, input br_ops_e br,
                            input alu_opr1_sel_e opr1, input alu_opr2_sel_e opr2,
                            input alu_cmp_opr2_sel_e cmp, input rd_wrb_sel_e wrb,
                            input logic [2:0] reqs, input logic [31:0] imm);
      vector_t v;
      v = '{instr, 1'b0, EXC_CODE_NONE, alu, ld, st, br, opr1, opr2, cmp, wrb, reqs,
            1'b0, EXC_CODE_NONE, imm};
      vectors.push_back(v);
   endtask

   // Rows where every control is cancelled and only the exception remains
   task automatic add_cancel(input logic [31:0] instr, input logic fetch_req,
                             input exc_code_e code, input logic [31:0] imm);
      vector_t v;
      v = '{instr, fetch_req, fetch_req ? code : EXC_CODE_NONE, ALU_OPS_NONE, LD_OPS_NONE,
            ST_OPS_NONE, BR_OPS_NONE, ALU_OPR1_PC, ALU_OPR2_IMM, ALU_CMP_OPR2_REG,
            RD_WRB_NONE, 3'b000, 1'b1, code, imm};
      vectors.push_back(v);
   endtask

   task automatic load_vectors();
      add_legal(32'h002081B3, ALU_OPS_ADD, LD_OPS_NONE, ST_OPS_NONE, BR_OPS_NONE,  // add
                ALU_OPR1_REG, ALU_OPR2_REG, ALU_CMP_OPR2_REG, RD_WRB_ALU, 3'b100, 32'h2);
      add_legal(32'h402081B3, ALU_OPS_SUB, LD_OPS_NONE, ST_OPS_NONE, BR_OPS_NONE,  // sub
                ALU_OPR1_REG, ALU_OPR2_REG, ALU_CMP_OPR2_REG, RD_WRB_ALU, 3'b100, 32'h402);
      add_legal(32'h407352B3, ALU_OPS_SRA, LD_OPS_NONE, ST_OPS_NONE, BR_OPS_NONE,  // sra
                ALU_OPR1_REG, ALU_OPR2_REG, ALU_CMP_OPR2_REG, RD_WRB_ALU, 3'b100, 32'h407);
      add_legal(32'h00C5F533, ALU_OPS_AND, LD_OPS_NONE, ST_OPS_NONE, BR_OPS_NONE,  // and
                ALU_OPR1_REG, ALU_OPR2_REG, ALU_CMP_OPR2_REG, RD_WRB_ALU, 3'b100, 32'hC);
      add_legal(32'h002091B3, ALU_OPS_SLL, LD_OPS_NONE, ST_OPS_NONE, BR_OPS_NONE,  // sll
                ALU_OPR1_REG, ALU_OPR2_REG, ALU_CMP_OPR2_REG, RD_WRB_ALU, 3'b100, 32'h2);
      add_legal(32'h0020A1B3, ALU_OPS_SLT, LD_OPS_NONE, ST_OPS_NONE, BR_OPS_NONE,  // slt
                ALU_OPR1_REG, ALU_OPR2_REG, ALU_CMP_OPR2_REG, RD_WRB_ALU, 3'b100, 32'h2);
      add_legal(32'h0020B1B3, ALU_OPS_SLTU, LD_OPS_NONE, ST_OPS_NONE, BR_OPS_NONE, // sltu
                ALU_OPR1_REG, ALU_OPR2_REG, ALU_CMP_OPR2_REG, RD_WRB_ALU, 3'b100, 32'h2);
      add_legal(32'h0020C1B3, ALU_OPS_XOR, LD_OPS_NONE, ST_OPS_NONE, BR_OPS_NONE,  // xor
                ALU_OPR1_REG, ALU_OPR2_REG, ALU_CMP_OPR2_REG, RD_WRB_ALU, 3'b100, 32'h2);
      add_legal(32'h0020D1B3, ALU_OPS_SRL, LD_OPS_NONE, ST_OPS_NONE, BR_OPS_NONE,  // srl
                ALU_OPR1_REG, ALU_OPR2_REG, ALU_CMP_OPR2_REG, RD_WRB_ALU, 3'b100, 32'h2);
      add_legal(32'h0020E1B3, ALU_OPS_OR, LD_OPS_NONE, ST_OPS_NONE, BR_OPS_NONE,   // or
                ALU_OPR1_REG, ALU_OPR2_REG, ALU_CMP_OPR2_REG, RD_WRB_ALU, 3'b100, 32'h2);
      add_legal(32'hFFF10093, ALU_OPS_ADD, LD_OPS_NONE, ST_OPS_NONE, BR_OPS_NONE,  // addi -1
                ALU_OPR1_REG, ALU_OPR2_IMM, ALU_CMP_OPR2_IMM, RD_WRB_ALU, 3'b100, 32'hFFFFFFFF);
      add_legal(32'hFFB12093, ALU_OPS_SLT, LD_OPS_NONE, ST_OPS_NONE, BR_OPS_NONE,  // slti -5
                ALU_OPR1_REG, ALU_OPR2_IMM, ALU_CMP_OPR2_IMM, RD_WRB_ALU, 3'b100, 32'hFFFFFFFB);
      add_legal(32'h00713093, ALU_OPS_SLTU, LD_OPS_NONE, ST_OPS_NONE, BR_OPS_NONE, // sltiu 7
                ALU_OPR1_REG, ALU_OPR2_IMM, ALU_CMP_OPR2_IMM, RD_WRB_ALU, 3'b100, 32'h7);
      add_legal(32'h7FF14093, ALU_OPS_XOR, LD_OPS_NONE, ST_OPS_NONE, BR_OPS_NONE,  // xori 2047
                ALU_OPR1_REG, ALU_OPR2_IMM, ALU_CMP_OPR2_IMM, RD_WRB_ALU, 3'b100, 32'h7FF);
      add_legal(32'h10016093, ALU_OPS_OR, LD_OPS_NONE, ST_OPS_NONE, BR_OPS_NONE,   // ori 256
                ALU_OPR1_REG, ALU_OPR2_IMM, ALU_CMP_OPR2_IMM, RD_WRB_ALU, 3'b100, 32'h100);
      add_legal(32'hF0017093, ALU_OPS_AND, LD_OPS_NONE, ST_OPS_NONE, BR_OPS_NONE,  // andi -256
                ALU_OPR1_REG, ALU_OPR2_IMM, ALU_CMP_OPR2_IMM, RD_WRB_ALU, 3'b100, 32'hFFFFFF00);
      add_legal(32'h01F11093, ALU_OPS_SLL, LD_OPS_NONE, ST_OPS_NONE, BR_OPS_NONE,  // slli 31
                ALU_OPR1_REG, ALU_OPR2_IMM, ALU_CMP_OPR2_IMM, RD_WRB_ALU, 3'b100, 32'h1F);
      add_legal(32'h00C15093, ALU_OPS_SRL, LD_OPS_NONE, ST_OPS_NONE, BR_OPS_NONE,  // srli 12
                ALU_OPR1_REG, ALU_OPR2_IMM, ALU_CMP_OPR2_IMM, RD_WRB_ALU, 3'b100, 32'hC);
      add_legal(32'h40515093, ALU_OPS_SRA, LD_OPS_NONE, ST_OPS_NONE, BR_OPS_NONE,  // srai 5
                ALU_OPR1_REG, ALU_OPR2_IMM, ALU_CMP_OPR2_IMM, RD_WRB_ALU, 3'b100, 32'h5);
      add_legal(32'h123452B7, ALU_OPS_COPY_OPR2, LD_OPS_NONE, ST_OPS_NONE, BR_OPS_NONE,
                ALU_OPR1_PC, ALU_OPR2_IMM, ALU_CMP_OPR2_REG, RD_WRB_ALU, 3'b100, 32'h12345000);
      add_legal(32'hFFFFF297, ALU_OPS_ADD, LD_OPS_NONE, ST_OPS_NONE, BR_OPS_NONE,  // auipc
                ALU_OPR1_PC, ALU_OPR2_IMM, ALU_CMP_OPR2_REG, RD_WRB_ALU, 3'b100, 32'hFFFFF000);
      add_legal(32'hFFC3A303, ALU_OPS_ADD, LD_OPS_LW, ST_OPS_NONE, BR_OPS_NONE,    // lw -4
                ALU_OPR1_REG, ALU_OPR2_IMM, ALU_CMP_OPR2_REG, RD_WRB_DMEM, 3'b100, 32'hFFFFFFFC);
      add_legal(32'hFE532C23, ALU_OPS_ADD, LD_OPS_NONE, ST_OPS_SW, BR_OPS_NONE,    // sw -8
                ALU_OPR1_REG, ALU_OPR2_IMM, ALU_CMP_OPR2_REG, RD_WRB_NONE, 3'b000, 32'hFFFFFFF8);
      add_legal(32'h00208463, ALU_OPS_ADD, LD_OPS_NONE, ST_OPS_NONE, BR_OPS_EQ,    // beq +8
                ALU_OPR1_PC, ALU_OPR2_IMM, ALU_CMP_OPR2_REG, RD_WRB_NONE, 3'b001, 32'h8);
      add_legal(32'hFE20FEE3, ALU_OPS_ADD, LD_OPS_NONE, ST_OPS_NONE, BR_OPS_GEU,   // bgeu -4
                ALU_OPR1_PC, ALU_OPR2_IMM, ALU_CMP_OPR2_REG, RD_WRB_NONE, 3'b001, 32'hFFFFFFFC);
      add_legal(32'hFFFFF06F, ALU_OPS_ADD, LD_OPS_NONE, ST_OPS_NONE, BR_OPS_NONE,  // jal -2
                ALU_OPR1_PC, ALU_OPR2_IMM, ALU_CMP_OPR2_REG, RD_WRB_INC_PC, 3'b110, 32'hFFFFFFFE);
      add_legal(32'hFF0280E7, ALU_OPS_ADD, LD_OPS_NONE, ST_OPS_NONE, BR_OPS_NONE,  // jalr -16
                ALU_OPR1_REG, ALU_OPR2_IMM, ALU_CMP_OPR2_REG, RD_WRB_INC_PC, 3'b110, 32'hFFFFFFF0);
      add_cancel(32'h00000000, 1'b0, EXC_CODE_ILLEGAL_INSTR, 32'h0);       // All zero word
      add_cancel(32'h0000007F, 1'b0, EXC_CODE_ILLEGAL_INSTR, 32'h0);       // Unknown opcode
      add_cancel(32'h022081B3, 1'b0, EXC_CODE_ILLEGAL_INSTR, 32'h22);      // mul
      add_cancel(32'h0003B303, 1'b0, EXC_CODE_ILLEGAL_INSTR, 32'h0);       // Load funct3 3
      add_cancel(32'h00533023, 1'b0, EXC_CODE_ILLEGAL_INSTR, 32'h5);       // Store funct3 3
      add_cancel(32'h0020A463, 1'b0, EXC_CODE_ILLEGAL_INSTR, 32'h2);       // Branch funct3 2
      add_cancel(32'h40111093, 1'b0, EXC_CODE_ILLEGAL_INSTR, 32'h401);     // slli, bad funct7
      add_cancel(32'h002081B3, 1'b1, EXC_CODE_INSTR_ACCESS_FAULT, 32'h2);  // Fault on add
      add_cancel(32'h0000007F, 1'b1, EXC_CODE_INSTR_ACCESS_FAULT, 32'h0);  // Fault on illegal
   endtask

`endif

// File: verif/tb_decode_stage.sv
// Testbench for the decode stage with vector table, LFSR stimulus and register file checks
`timescale 1ns/1ps
`default_nettype none

module tb_decode_stage import decode_pkg::*; ();

   localparam int  XLEN        = 32;
   localparam int  CLK_PERIOD  = 10;
   localparam int  RF_WRITES   = 48;               // Write and read-back rounds
   localparam int  WATCHDOG_NS = 100000;
   localparam logic [31:0] LFSR_SEED = 32'd86059;

   logic              clk;
   logic              reset_i;
   logic [31:0]       instr;
   logic              fetch_exc_req;
   exc_code_e         fetch_exc_code;
   logic              wrb_req;
   logic [4:0]        wrb_addr;
   logic [XLEN-1:0]   wrb_data;
   alu_ops_e          alu_ops;
   ld_ops_e           ld_ops;
   st_ops_e           st_ops;
   br_ops_e           br_ops;
   alu_opr1_sel_e     opr1_sel;
   alu_opr2_sel_e     opr2_sel;
   alu_cmp_opr2_sel_e cmp_sel;
   rd_wrb_sel_e       wrb_sel;
   logic              rd_wr_req;
   logic              jump_req;
   logic              branch_req;
   logic              exc_req;
   exc_code_e         exc_code;
   logic [XLEN-1:0]   imm;
   logic [XLEN-1:0]   rs1_data;
   logic [XLEN-1:0]   rs2_data;
   logic [4:0]        rd_addr;

   logic [31:0]       lfsr_state;
   logic [XLEN-1:0]   shadow [32];                 // Expected register contents

`include "tb_decode_vectors.svh"

   decode_stage #(.XLEN(XLEN)) dut (
      .clk(clk), .reset_i(reset_i), .instr_i(instr),
      .fetch_exc_req_i(fetch_exc_req), .fetch_exc_code_i(fetch_exc_code),
      .wrb_rd_wr_req_i(wrb_req), .wrb_rd_addr_i(wrb_addr), .wrb_rd_data_i(wrb_data),
      .alu_ops_o(alu_ops), .ld_ops_o(ld_ops), .st_ops_o(st_ops), .br_ops_o(br_ops),
      .alu_opr1_sel_o(opr1_sel), .alu_opr2_sel_o(opr2_sel), .alu_cmp_opr2_sel_o(cmp_sel),
      .rd_wrb_sel_o(wrb_sel), .rd_wr_req_o(rd_wr_req), .jump_req_o(jump_req),
      .branch_req_o(branch_req), .exc_req_o(exc_req), .exc_code_o(exc_code),
      .imm_o(imm), .rs1_data_o(rs1_data), .rs2_data_o(rs2_data), .rd_addr_o(rd_addr)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   task automatic stop_on_failure();
      $display("Something failed");
      $fatal(1, "Run stopped at the first failure");
   endtask

   task automatic check_value(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
      if (actual !== expected) begin
         $display("ERROR at %0t ns: %s expected %h got %h", $time, name, expected, actual);
         stop_on_failure();
      end
   endtask

   task automatic wait_cycles(input int n);
      for (int i = 0; i < n; i++) begin
         @(posedge clk);
      end
   endtask

   function automatic logic lfsr_bit();
      logic out;
      out        = lfsr_state[0];
      lfsr_state = lfsr_state >> 1;
      if (out) lfsr_state = lfsr_state ^ 32'hD000_0001;  // Galois taps 32, 31, 29, 1
      return out;
   endfunction

   function automatic logic [31:0] random_bits(input int n);
      logic [31:0] value;
      value = '0;
      for (int i = 0; i < n; i++) begin
         value = {value[30:0], lfsr_bit()};
      end
      return value;
   endfunction

   // An add that only serves to put rs1 and rs2 on the read ports
   function automatic logic [31:0] read_word(input logic [4:0] rs1, input logic [4:0] rs2);
      return {7'b0, rs2, rs1, 3'b000, 5'b00000, 7'b0110011};
   endfunction

   task automatic check_vector(input vector_t v);
      check_value("alu_ops_o", 64'(v.alu), 64'(alu_ops));
      check_value("ld_ops_o", 64'(v.ld), 64'(ld_ops));
      check_value("st_ops_o", 64'(v.st), 64'(st_ops));
      check_value("br_ops_o", 64'(v.br), 64'(br_ops));
      check_value("alu_opr1_sel_o", 64'(v.opr1), 64'(opr1_sel));
      check_value("alu_opr2_sel_o", 64'(v.opr2), 64'(opr2_sel));
      check_value("alu_cmp_opr2_sel_o", 64'(v.cmp), 64'(cmp_sel));
      check_value("rd_wrb_sel_o", 64'(v.wrb), 64'(wrb_sel));
      check_value("rd_wr_req_o", 64'(v.reqs[2]), 64'(rd_wr_req));
      check_value("jump_req_o", 64'(v.reqs[1]), 64'(jump_req));
      check_value("branch_req_o", 64'(v.reqs[0]), 64'(branch_req));
      check_value("exc_req_o", 64'(v.exc), 64'(exc_req));
      check_value("exc_code_o", 64'(v.code), 64'(exc_code));
      check_value("imm_o", 64'(v.imm), 64'(imm));
      check_value("rd_addr_o", 64'(v.instr[11:7]), 64'(rd_addr));
   endtask

   task automatic check_reads(input logic [4:0] rs1, input logic [4:0] rs2);
      check_value("rs1_data_o", 64'(shadow[rs1]), 64'(rs1_data));
      check_value("rs2_data_o", 64'(shadow[rs2]), 64'(rs2_data));
   endtask

   initial begin
      #(WATCHDOG_NS);
      $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
      stop_on_failure();
   end

   initial begin
      logic [31:0] pick;
      logic [4:0]  addr;
      logic [4:0]  other;
      logic [31:0] data;
      int          kind;

      reset_i        = 1'b1;
      instr          = '0;                         // Illegal word while in reset
      fetch_exc_req  = 1'b0;
      fetch_exc_code = EXC_CODE_NONE;
      wrb_req        = 1'b0;
      wrb_addr       = '0;
      wrb_data       = '0;
      lfsr_state     = LFSR_SEED;
      for (int r = 0; r < 32; r++) begin
         shadow[r] = '0;
      end
      load_vectors();

      wait_cycles(2);
      #(CLK_PERIOD - 1);
      check_value("exc_req_o", 64'(1'b1), 64'(exc_req));
      check_value("alu_ops_o", 64'(ALU_OPS_NONE), 64'(alu_ops));
      wait_cycles(1);
      #1 reset_i = 1'b0;

      foreach (vectors[i]) begin
         instr          = vectors[i].instr;
         fetch_exc_req  = vectors[i].fetch_req;
         fetch_exc_code = vectors[i].fetch_code;
         #(CLK_PERIOD - 2);
         check_vector(vectors[i]);
         wait_cycles(1);
         #1;
      end
      fetch_exc_req  = 1'b0;
      fetch_exc_code = EXC_CODE_NONE;

      for (int i = 0; i < RF_WRITES; i++) begin
         kind  = i % 8;
         pick  = random_bits(5);
         addr  = (kind == 0) ? 5'd0 : pick[4:0];
         pick  = random_bits(5);
         other = pick[4:0];
         data  = random_bits(32);
         wrb_req  = (kind != 4);
         wrb_addr = addr;
         wrb_data = data;
         instr    = read_word(addr, other);
         #(CLK_PERIOD - 2);
         check_reads(addr, other);                 // Old value, no bypass
         wait_cycles(1);
         if (wrb_req && addr != 5'd0) shadow[addr] = data;
         #1 wrb_req = 1'b0;
         #(CLK_PERIOD - 2);
         check_reads(addr, other);
         wait_cycles(1);
         #1;
      end

      reset_i = 1'b1;                              // Reset again over the written registers
      instr   = '0;
      wait_cycles(3);
      #1 reset_i = 1'b0;
      for (int r = 0; r < 32; r++) begin
         shadow[r] = '0;
      end

      for (int r = 0; r < 32; r++) begin           // Everything cleared by reset
         instr = read_word(5'(r), 5'(31 - r));
         #(CLK_PERIOD - 2);
         check_reads(5'(r), 5'(31 - r));
         wait_cycles(1);
         #1;
      end

      $display("Everything OK");
      $finish;
   end

endmodule : tb_decode_stage

`default_nettype wire

// File: design/decode_stage.sv
// Decode stage top level with control decoder, immediate generator and register file
`timescale 1ns/1ps
`default_nettype none

module decode_stage import decode_pkg::*; #(
   parameter int XLEN = 32
) (
   input  wire                   clk,
   input  wire                   reset_i,
   input  wire [INSTR_WIDTH-1:0] instr_i,            // From fetch
   input  wire                   fetch_exc_req_i,
   input  wire exc_code_e        fetch_exc_code_i,
   input  wire                   wrb_rd_wr_req_i,    // From writeback
   input  wire [RF_AWIDTH-1:0]   wrb_rd_addr_i,
   input  wire [XLEN-1:0]        wrb_rd_data_i,
   output alu_ops_e              alu_ops_o,
   output ld_ops_e               ld_ops_o,
   output st_ops_e               st_ops_o,
   output br_ops_e               br_ops_o,
   output alu_opr1_sel_e         alu_opr1_sel_o,
   output alu_opr2_sel_e         alu_opr2_sel_o,
   output alu_cmp_opr2_sel_e     alu_cmp_opr2_sel_o,
   output rd_wrb_sel_e           rd_wrb_sel_o,
   output logic                  rd_wr_req_o,
   output logic                  jump_req_o,
   output logic                  branch_req_o,
   output logic                  exc_req_o,
   output exc_code_e             exc_code_o,
   output logic [XLEN-1:0]       imm_o,
   output logic [XLEN-1:0]       rs1_data_o,
   output logic [XLEN-1:0]       rs2_data_o,
   output logic [RF_AWIDTH-1:0]  rd_addr_o
);

   imm_fmt_e             imm_fmt;                    // Decoder to immediate generator
   logic [RF_AWIDTH-1:0] rs1_addr;
   logic [RF_AWIDTH-1:0] rs2_addr;

   assign rs1_addr  = instr_i[19:15];
   assign rs2_addr  = instr_i[24:20];
   assign rd_addr_o = instr_i[11:7];

   ctrl_decoder u_ctrl_decoder (
      .instr_i            (instr_i),
      .fetch_exc_req_i    (fetch_exc_req_i),
      .fetch_exc_code_i   (fetch_exc_code_i),
      .alu_ops_o          (alu_ops_o),
      .ld_ops_o           (ld_ops_o),
      .st_ops_o           (st_ops_o),
      .br_ops_o           (br_ops_o),
      .alu_opr1_sel_o     (alu_opr1_sel_o),
      .alu_opr2_sel_o     (alu_opr2_sel_o),
      .alu_cmp_opr2_sel_o (alu_cmp_opr2_sel_o),
      .rd_wrb_sel_o       (rd_wrb_sel_o),
      .imm_fmt_o          (imm_fmt),
      .rd_wr_req_o        (rd_wr_req_o),
      .jump_req_o         (jump_req_o),
      .branch_req_o       (branch_req_o),
      .exc_req_o          (exc_req_o),
      .exc_code_o         (exc_code_o)
   );

   imm_gen #(.XLEN(XLEN)) u_imm_gen (
      .instr_i   (instr_i),
      .imm_fmt_i (imm_fmt),
      .imm_o     (imm_o)
   );

   reg_file #(.XLEN(XLEN)) u_reg_file (
      .clk         (clk),
      .reset_i     (reset_i),
      .rs1_addr_i  (rs1_addr),
      .rs2_addr_i  (rs2_addr),
      .rd_wr_req_i (wrb_rd_wr_req_i),
      .rd_addr_i   (wrb_rd_addr_i),
      .rd_data_i   (wrb_rd_data_i),
      .rs1_data_o  (rs1_data_o),
      .rs2_data_o  (rs2_data_o)
   );

endmodule : decode_stage

`default_nettype wire

// File: design/reg_file.sv
// Register file with two combinational read ports and one synchronous write port
`timescale 1ns/1ps
`default_nettype none

module reg_file import decode_pkg::*; #(
   parameter int XLEN = 32
) (
   input  wire                 clk,
   input  wire                 reset_i,
   input  wire [RF_AWIDTH-1:0] rs1_addr_i,
   input  wire [RF_AWIDTH-1:0] rs2_addr_i,
   input  wire                 rd_wr_req_i,
   input  wire [RF_AWIDTH-1:0] rd_addr_i,
   input  wire [XLEN-1:0]      rd_data_i,
   output logic [XLEN-1:0]     rs1_data_o,
   output logic [XLEN-1:0]     rs2_data_o
);

   logic [XLEN-1:0] regs [RF_DEPTH];

   always_ff @(posedge clk) begin
      if (reset_i) begin
         for (int i = 0; i < RF_DEPTH; i++) begin
            regs[i] <= '0;
         end
      end else if (rd_wr_req_i && (rd_addr_i != '0)) begin  // x0 is never written
         regs[rd_addr_i] <= rd_data_i;
      end
   end

   // No bypass, a write shows up after the clock edge
   assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
   assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

endmodule : reg_file

`default_nettype wire

// File: design/ctrl_decoder.sv
// Instruction classifier driving execute controls, immediate format and exception
`timescale 1ns/1ps
`default_nettype none

module ctrl_decoder import decode_pkg::*; (
   input  wire [INSTR_WIDTH-1:0] instr_i,
   input  wire                   fetch_exc_req_i,
   input  wire exc_code_e        fetch_exc_code_i,
   output alu_ops_e              alu_ops_o,
   output ld_ops_e               ld_ops_o,
   output st_ops_e               st_ops_o,
   output br_ops_e               br_ops_o,
   output alu_opr1_sel_e         alu_opr1_sel_o,
   output alu_opr2_sel_e         alu_opr2_sel_o,
   output alu_cmp_opr2_sel_e     alu_cmp_opr2_sel_o,
   output rd_wrb_sel_e           rd_wrb_sel_o,
   output imm_fmt_e              imm_fmt_o,
   output logic                  rd_wr_req_o,
   output logic                  jump_req_o,
   output logic                  branch_req_o,
   output logic                  exc_req_o,
   output exc_code_e             exc_code_o
);

   rv_opcode_e opcode;
   logic [2:0] funct3;
   logic [6:0] funct7;
   logic       illegal_instr;

   assign opcode = rv_opcode_e'(instr_i[6:2]);
   assign funct3 = instr_i[14:12];
   assign funct7 = instr_i[31:25];

   always_comb begin
      alu_ops_o          = ALU_OPS_NONE;
      ld_ops_o           = LD_OPS_NONE;
      st_ops_o           = ST_OPS_NONE;
      br_ops_o           = BR_OPS_NONE;
      alu_opr1_sel_o     = ALU_OPR1_PC;
      alu_opr2_sel_o     = ALU_OPR2_IMM;
      alu_cmp_opr2_sel_o = ALU_CMP_OPR2_REG;
      rd_wrb_sel_o       = RD_WRB_NONE;
      imm_fmt_o          = IMM_FMT_I;
      rd_wr_req_o        = 1'b0;
      jump_req_o         = 1'b0;
      branch_req_o       = 1'b0;
      exc_req_o          = 1'b0;
      exc_code_o         = EXC_CODE_NONE;
      illegal_instr      = 1'b0;

      if (fetch_exc_req_i) begin
         exc_req_o  = 1'b1;                        // Fetch fault wins, no decoding
         exc_code_o = fetch_exc_code_i;
      end else if (instr_i[1:0] != 2'b11) begin
         illegal_instr = 1'b1;                     // Compressed encodings not supported
      end else begin
         case (opcode)
            OPCODE_ARITH_INST : begin
               alu_opr1_sel_o = ALU_OPR1_REG;
               alu_opr2_sel_o = ALU_OPR2_REG;
               rd_wrb_sel_o   = RD_WRB_ALU;
               rd_wr_req_o    = 1'b1;
               case (funct7)
                  7'b0000000 : begin
                     case (funct3)
                        3'b000  : alu_ops_o = ALU_OPS_ADD;
                        3'b001  : alu_ops_o = ALU_OPS_SLL;
                        3'b010  : alu_ops_o = ALU_OPS_SLT;
                        3'b011  : alu_ops_o = ALU_OPS_SLTU;
                        3'b100  : alu_ops_o = ALU_OPS_XOR;
                        3'b101  : alu_ops_o = ALU_OPS_SRL;
                        3'b110  : alu_ops_o = ALU_OPS_OR;
                        default : alu_ops_o = ALU_OPS_AND;
                     endcase
                  end
                  7'b0100000 : begin
                     case (funct3)
                        3'b000  : alu_ops_o     = ALU_OPS_SUB;
                        3'b101  : alu_ops_o     = ALU_OPS_SRA;
                        default : illegal_instr = 1'b1;
                     endcase
                  end
                  default : illegal_instr = 1'b1;  // M extension included
               endcase
            end
            OPCODE_IMM_INST : begin
               alu_opr1_sel_o     = ALU_OPR1_REG;
               alu_cmp_opr2_sel_o = ALU_CMP_OPR2_IMM;
               rd_wrb_sel_o       = RD_WRB_ALU;
               rd_wr_req_o        = 1'b1;
               case (funct3)
                  3'b000 : alu_ops_o = ALU_OPS_ADD;
                  3'b010 : alu_ops_o = ALU_OPS_SLT;
                  3'b011 : alu_ops_o = ALU_OPS_SLTU;
                  3'b100 : alu_ops_o = ALU_OPS_XOR;
                  3'b110 : alu_ops_o = ALU_OPS_OR;
                  3'b111 : alu_ops_o = ALU_OPS_AND;
                  3'b001 : begin
                     imm_fmt_o = IMM_FMT_SHAMT;
                     if (funct7 == 7'b0000000) alu_ops_o = ALU_OPS_SLL;
                     else illegal_instr = 1'b1;
                  end
                  default : begin                  // SRLI or SRAI
                     imm_fmt_o = IMM_FMT_SHAMT;
                     case (funct7)
                        7'b0000000 : alu_ops_o     = ALU_OPS_SRL;
                        7'b0100000 : alu_ops_o     = ALU_OPS_SRA;
                        default    : illegal_instr = 1'b1;
                     endcase
                  end
               endcase
            end
            OPCODE_AUIPC_INST : begin
               alu_ops_o    = ALU_OPS_ADD;         // PC plus upper immediate
               rd_wrb_sel_o = RD_WRB_ALU;
               imm_fmt_o    = IMM_FMT_U;
               rd_wr_req_o  = 1'b1;
            end
            OPCODE_LUI_INST : begin
               alu_ops_o    = ALU_OPS_COPY_OPR2;
               rd_wrb_sel_o = RD_WRB_ALU;
               imm_fmt_o    = IMM_FMT_U;
               rd_wr_req_o  = 1'b1;
            end
            OPCODE_LOAD_INST : begin
               alu_opr1_sel_o = ALU_OPR1_REG;
               alu_ops_o      = ALU_OPS_ADD;       // Address calculation
               rd_wrb_sel_o   = RD_WRB_DMEM;
               rd_wr_req_o    = 1'b1;
               case (funct3)
                  3'b000  : ld_ops_o      = LD_OPS_LB;
                  3'b001  : ld_ops_o      = LD_OPS_LH;
                  3'b010  : ld_ops_o      = LD_OPS_LW;
                  3'b100  : ld_ops_o      = LD_OPS_LBU;
                  3'b101  : ld_ops_o      = LD_OPS_LHU;
                  default : illegal_instr = 1'b1;
               endcase
            end
            OPCODE_STORE_INST : begin
               alu_opr1_sel_o = ALU_OPR1_REG;
               alu_ops_o      = ALU_OPS_ADD;
               imm_fmt_o      = IMM_FMT_S;
               case (funct3)
                  3'b000  : st_ops_o      = ST_OPS_SB;
                  3'b001  : st_ops_o      = ST_OPS_SH;
                  3'b010  : st_ops_o      = ST_OPS_SW;
                  default : illegal_instr = 1'b1;
               endcase
            end
            OPCODE_BRANCH_INST : begin
               alu_ops_o    = ALU_OPS_ADD;         // Target is PC plus offset
               imm_fmt_o    = IMM_FMT_B;
               branch_req_o = 1'b1;
               case (funct3)
                  3'b000  : br_ops_o      = BR_OPS_EQ;
                  3'b001  : br_ops_o      = BR_OPS_NE;
                  3'b100  : br_ops_o      = BR_OPS_LT;
                  3'b101  : br_ops_o      = BR_OPS_GE;
                  3'b110  : br_ops_o      = BR_OPS_LTU;
                  3'b111  : br_ops_o      = BR_OPS_GEU;
                  default : illegal_instr = 1'b1;
               endcase
            end
            OPCODE_JALR_INST : begin
               alu_opr1_sel_o = ALU_OPR1_REG;
               alu_ops_o      = ALU_OPS_ADD;
               rd_wrb_sel_o   = RD_WRB_INC_PC;     // Link address
               rd_wr_req_o    = 1'b1;
               jump_req_o     = 1'b1;
            end
            OPCODE_JAL_INST : begin
               alu_ops_o    = ALU_OPS_ADD;
               rd_wrb_sel_o = RD_WRB_INC_PC;
               imm_fmt_o    = IMM_FMT_J;
               rd_wr_req_o  = 1'b1;
               jump_req_o   = 1'b1;
            end
            default : illegal_instr = 1'b1;        // Unsupported opcode
         endcase
      end

      // Cancel every control of an illegal instruction
      if (illegal_instr) begin
         alu_ops_o          = ALU_OPS_NONE;
         ld_ops_o           = LD_OPS_NONE;
         st_ops_o           = ST_OPS_NONE;
         br_ops_o           = BR_OPS_NONE;
         alu_opr1_sel_o     = ALU_OPR1_PC;
         alu_opr2_sel_o     = ALU_OPR2_IMM;
         alu_cmp_opr2_sel_o = ALU_CMP_OPR2_REG;
         rd_wrb_sel_o       = RD_WRB_NONE;
         imm_fmt_o          = IMM_FMT_I;
         rd_wr_req_o        = 1'b0;
         jump_req_o         = 1'b0;
         branch_req_o       = 1'b0;
         exc_req_o          = 1'b1;
         exc_code_o         = EXC_CODE_ILLEGAL_INSTR;
      end
   end

endmodule : ctrl_decoder

`default_nettype wire

// File: design/imm_gen.sv
// Immediate generator for the I, SHAMT, S, B, U and J formats
`timescale 1ns/1ps
`default_nettype none

module imm_gen import decode_pkg::*; #(
   parameter int XLEN = 32
) (
   input  wire [INSTR_WIDTH-1:0] instr_i,
   input  wire imm_fmt_e         imm_fmt_i,
   output logic [XLEN-1:0]       imm_o
);

   logic [INSTR_WIDTH-1:0] imm_word;               // Immediate before extension to XLEN

   always_comb begin
      case (imm_fmt_i)
         IMM_FMT_SHAMT : imm_word = {27'b0, instr_i[24:20]};
         IMM_FMT_S     : imm_word = {{21{instr_i[31]}}, instr_i[30:25], instr_i[11:7]};
         IMM_FMT_B     : imm_word = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25],
                                     instr_i[11:8], 1'b0};
         IMM_FMT_U     : imm_word = {instr_i[31:12], 12'b0};
         IMM_FMT_J     : imm_word = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20],
                                     instr_i[30:21], 1'b0};
         default       : imm_word = {{21{instr_i[31]}}, instr_i[30:20]};  // I format
      endcase
   end

   // All formats carry their sign in bit 31, SHAMT has it clear
   assign imm_o = XLEN'($signed(imm_word));

endmodule : imm_gen

`default_nettype wire

// File: design/decode_pkg.sv
// Decode widths, opcode and control enumerations, immediate formats, exception codes
`default_nettype none

package decode_pkg;

   parameter int INSTR_WIDTH = 32;                 // Instruction word
   parameter int RF_AWIDTH   = 5;                  // Register address
   parameter int RF_DEPTH    = 1 << RF_AWIDTH;     // Number of registers

   // Major opcodes, taken from instruction bits 6 to 2
   typedef enum logic [4:0] {
      OPCODE_LOAD_INST   = 5'b00000,
      OPCODE_IMM_INST    = 5'b00100,
      OPCODE_AUIPC_INST  = 5'b00101,
      OPCODE_STORE_INST  = 5'b01000,
      OPCODE_ARITH_INST  = 5'b01100,
      OPCODE_LUI_INST    = 5'b01101,
      OPCODE_BRANCH_INST = 5'b11000,
      OPCODE_JALR_INST   = 5'b11001,
      OPCODE_JAL_INST    = 5'b11011
   } rv_opcode_e;

   typedef enum logic [3:0] {
      ALU_OPS_NONE,
      ALU_OPS_ADD,
      ALU_OPS_SUB,
      ALU_OPS_SLL,
      ALU_OPS_SLT,
      ALU_OPS_SLTU,
      ALU_OPS_XOR,
      ALU_OPS_SRL,
      ALU_OPS_SRA,
      ALU_OPS_OR,
      ALU_OPS_AND,
      ALU_OPS_COPY_OPR2                            // Pass operand 2, used by LUI
   } alu_ops_e;

   typedef enum logic [2:0] {
      LD_OPS_NONE, LD_OPS_LB, LD_OPS_LH, LD_OPS_LW, LD_OPS_LBU, LD_OPS_LHU
   } ld_ops_e;

   typedef enum logic [1:0] {
      ST_OPS_NONE, ST_OPS_SB, ST_OPS_SH, ST_OPS_SW
   } st_ops_e;

   typedef enum logic [2:0] {
      BR_OPS_NONE, BR_OPS_EQ, BR_OPS_NE, BR_OPS_LT, BR_OPS_GE, BR_OPS_LTU, BR_OPS_GEU
   } br_ops_e;

   typedef enum logic {ALU_OPR1_PC, ALU_OPR1_REG} alu_opr1_sel_e;
   typedef enum logic {ALU_OPR2_REG, ALU_OPR2_IMM} alu_opr2_sel_e;
   typedef enum logic {ALU_CMP_OPR2_REG, ALU_CMP_OPR2_IMM} alu_cmp_opr2_sel_e;

   // Source of the value written back to rd
   typedef enum logic [1:0] {
      RD_WRB_NONE, RD_WRB_ALU, RD_WRB_DMEM, RD_WRB_INC_PC
   } rd_wrb_sel_e;

   typedef enum logic [2:0] {
      IMM_FMT_I,
      IMM_FMT_SHAMT,                               // Shift amount, zero-extended
      IMM_FMT_S,
      IMM_FMT_B,
      IMM_FMT_U,
      IMM_FMT_J
   } imm_fmt_e;

   typedef enum logic [3:0] {
      EXC_CODE_INSTR_ACCESS_FAULT = 4'd1,
      EXC_CODE_ILLEGAL_INSTR      = 4'd2,
      EXC_CODE_NONE               = 4'd15
   } exc_code_e;

endpackage : decode_pkg

`default_nettype wire
